//--- logic/cart_pkg.sv
`default_nettype none

package cart_pkg;

    // ************************************************************
    // Console bus types
    // ************************************************************
    typedef logic [14:0] cpu_addr_t;  // CPU address below ROMSEL.
    typedef logic [13:0] ppu_addr_t;
    typedef logic [7:0]  bus_data_t;

    // ************************************************************
    // Window decode and mapper configuration
    // ************************************************************
    localparam int WINDOW_BITS = 13;  // One 8 KiB window.
    localparam logic [1:0] CPU_WIN_TAG = 2'b11;  // A14:A13 of 6000-7FFF.
    localparam int PPU_NT_BIT = 13;  // Set for nametable space.

    // [6] mirroring, [5:3] CHR bank, [2:0] PRG bank.
    typedef logic [6:0] map_cfg_t;
    localparam int BANK_BITS = 3;
    localparam int CFG_PRG_LSB = 0;
    localparam int CFG_CHR_LSB = 3;
    localparam int CFG_MIRROR_BIT = 6;  // 0 vertical, 1 horizontal.

endpackage

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [7:0] mem_data_t;

    // Owner of the current arbiter grant.
    typedef enum logic [1:0] {
        client_none,
        client_prg,
        client_chr
    } mem_client_e;

    // Client side of one memory channel.
    typedef enum logic [1:0] {
        idle,
        wait_ack,
        hold
    } chan_state_e;

endpackage

`default_nettype wire

//--- logic/mem_chan_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_chan_if #(
    parameter int MEM_ADDR_BITS = 15
) ();

    logic                     req;
    logic                     we;
    logic [MEM_ADDR_BITS-1:0] addr;
    mem_pkg::mem_data_t       wdata;
    mem_pkg::mem_data_t       rdata;  // Valid with ack.
    logic                     ack;  // One cycle pulse.

    modport controller (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    modport memory (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

`default_nettype wire

//--- logic/prg_port.sv
`timescale 1ns/10ps
`default_nettype none

module prg_port #(
    parameter int MEM_ADDR_BITS = 15
) (
    input  wire logic                clk,
    input  wire logic                async_nreset,
    input  wire logic                m2,
    input  wire cart_pkg::cpu_addr_t cpu_addr,
    input  wire cart_pkg::bus_data_t cpu_data_in,
    input  wire logic                cpu_rw,
    input  wire logic                romsel,
    output cart_pkg::bus_data_t      cpu_data_out,
    output logic                     cpu_oe,
    output cart_pkg::map_cfg_t       map_cfg,
    mem_chan_if.controller           mem
);

    localparam int BANK_W = MEM_ADDR_BITS - cart_pkg::WINDOW_BITS;

    logic [2:0]                    m2_s;
    logic [1:0]                    rw_s;
    logic [1:0]                    romsel_s;
    cart_pkg::cpu_addr_t           addr_meta;
    cart_pkg::cpu_addr_t           addr_s;
    cart_pkg::bus_data_t           data_meta;
    cart_pkg::bus_data_t           data_s;
    logic                          m2_rise;
    logic                          m2_fall;
    logic                          win_hit;
    logic                          rd_start;
    logic                          wr_start;
    logic                          cfg_load;
    logic [cart_pkg::BANK_BITS-1:0] prg_bank;
    mem_pkg::chan_state_e          state;
    logic                          req_we;
    logic [MEM_ADDR_BITS-1:0]      req_addr;
    cart_pkg::bus_data_t           req_wdata;

    // ************************************************************
    // Synchronizer and decode
    // ************************************************************
    always_ff @(posedge clk) begin
        rw_s      <= {rw_s[0], cpu_rw};
        romsel_s  <= {romsel_s[0], romsel};
        addr_meta <= cpu_addr;
        addr_s    <= addr_meta;
        data_meta <= cpu_data_in;
        data_s    <= data_meta;
    end

    assign m2_rise  = m2_s[1] && !m2_s[2];
    assign m2_fall  = !m2_s[1] && m2_s[2];
    assign win_hit  = addr_s[14:cart_pkg::WINDOW_BITS] == cart_pkg::CPU_WIN_TAG;
    assign prg_bank = map_cfg[cart_pkg::CFG_PRG_LSB +: cart_pkg::BANK_BITS];

    assign rd_start = state == mem_pkg::idle && m2_rise && rw_s[1] && romsel_s[1] && win_hit;
    assign wr_start = state == mem_pkg::idle && m2_fall && !rw_s[1] && romsel_s[1] && win_hit;
    assign cfg_load = m2_fall && !rw_s[1] && !romsel_s[1];  // Any write to ROM space.

    // ************************************************************
    // Mapper register and request FSM
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            m2_s    <= '0;
            state   <= mem_pkg::idle;
            map_cfg <= '0;
            cpu_oe  <= 1'b0;
        end else begin
            m2_s   <= {m2_s[1:0], m2};
            cpu_oe <= m2_s[1] && rw_s[1] && romsel_s[1] && win_hit;
            case (state)
                mem_pkg::idle: begin
                    if (rd_start || wr_start) begin
                        state <= mem_pkg::wait_ack;
                    end
                end
                mem_pkg::wait_ack: begin
                    if (mem.ack) begin
                        state <= mem_pkg::hold;
                    end
                end
                default: state <= mem_pkg::idle;  // Req stays low one cycle.
            endcase
            if (cfg_load) begin
                map_cfg <= data_s[6:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start || wr_start) begin
            req_we    <= wr_start;
            req_addr  <= {prg_bank[BANK_W-1:0], addr_s[cart_pkg::WINDOW_BITS-1:0]};
            req_wdata <= data_s;
        end
        if (state == mem_pkg::wait_ack && mem.ack && !req_we) begin
            cpu_data_out <= mem.rdata;
        end
    end

    assign mem.req   = state == mem_pkg::wait_ack;
    assign mem.we    = req_we;
    assign mem.addr  = req_addr;
    assign mem.wdata = req_wdata;

endmodule

`default_nettype wire

//--- logic/chr_port.sv
`timescale 1ns/10ps
`default_nettype none

module chr_port #(
    parameter int MEM_ADDR_BITS = 15
) (
    input  wire logic                clk,
    input  wire logic                async_nreset,
    input  wire logic                ppu_rd,
    input  wire logic                ppu_wr,
    input  wire cart_pkg::ppu_addr_t ppu_addr,
    input  wire cart_pkg::bus_data_t ppu_data_in,
    input  wire cart_pkg::map_cfg_t  map_cfg,
    output cart_pkg::bus_data_t      ppu_data_out,
    output logic                     ppu_oe,
    output logic                     ciram_a10,
    output logic                     ciram_ce,
    mem_chan_if.controller           mem
);

    localparam int BANK_W = MEM_ADDR_BITS - cart_pkg::WINDOW_BITS;

    logic [2:0]                     rd_s;  // Strobes idle high.
    logic [2:0]                     wr_s;
    cart_pkg::ppu_addr_t            addr_meta;
    cart_pkg::ppu_addr_t            addr_s;
    cart_pkg::bus_data_t            data_meta;
    cart_pkg::bus_data_t            data_s;
    logic                           pattern;
    logic                           rd_start;
    logic                           wr_start;
    logic [cart_pkg::BANK_BITS-1:0] chr_bank;
    mem_pkg::chan_state_e           state;
    logic                           req_we;
    logic [MEM_ADDR_BITS-1:0]       req_addr;
    cart_pkg::bus_data_t            req_wdata;

    always_ff @(posedge clk) begin
        addr_meta <= ppu_addr;
        addr_s    <= addr_meta;
        data_meta <= ppu_data_in;
        data_s    <= data_meta;
        ciram_a10 <= map_cfg[cart_pkg::CFG_MIRROR_BIT] ? addr_s[11] : addr_s[10];
    end

    assign pattern  = !addr_s[cart_pkg::PPU_NT_BIT];
    assign chr_bank = map_cfg[cart_pkg::CFG_CHR_LSB +: cart_pkg::BANK_BITS];
    assign rd_start = state == mem_pkg::idle && !rd_s[1] && rd_s[2] && pattern;
    assign wr_start = state == mem_pkg::idle && wr_s[1] && !wr_s[2] && pattern;

    // ************************************************************
    // Strobe tracking, nametable select and request FSM
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            rd_s     <= '1;
            wr_s     <= '1;
            state    <= mem_pkg::idle;
            ppu_oe   <= 1'b0;
            ciram_ce <= 1'b1;
        end else begin
            rd_s     <= {rd_s[1:0], ppu_rd};
            wr_s     <= {wr_s[1:0], ppu_wr};
            ppu_oe   <= !rd_s[1] && pattern;
            ciram_ce <= pattern;  // Low selects console VRAM.
            case (state)
                mem_pkg::idle: if (rd_start || wr_start) state <= mem_pkg::wait_ack;
                mem_pkg::wait_ack: if (mem.ack) state <= mem_pkg::hold;
                default: state <= mem_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start || wr_start) begin
            req_we    <= wr_start;
            req_addr  <= {chr_bank[BANK_W-1:0], addr_s[cart_pkg::WINDOW_BITS-1:0]};
            req_wdata <= data_s;
        end
        if (state == mem_pkg::wait_ack && mem.ack && !req_we) begin
            ppu_data_out <= mem.rdata;
        end
    end

    assign mem.req   = state == mem_pkg::wait_ack;
    assign mem.we    = req_we;
    assign mem.addr  = req_addr;
    assign mem.wdata = req_wdata;

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter #(
    parameter int MEM_ADDR_BITS = 15
) (
    input wire logic   clk,
    input wire logic   async_nreset,
    mem_chan_if.memory prg,
    mem_chan_if.memory chr
);

    mem_pkg::mem_data_t       ram [2**MEM_ADDR_BITS];
    mem_pkg::mem_data_t       rdata_q;
    mem_pkg::mem_client_e     grant_d;
    mem_pkg::mem_client_e     grant_q;
    logic                     sel_we;
    logic [MEM_ADDR_BITS-1:0] sel_addr;
    mem_pkg::mem_data_t       sel_wdata;

    // ************************************************************
    // Grant selection
    // ************************************************************
    // A client in its ack cycle still holds req, so it is skipped.
    always_comb begin
        grant_d = mem_pkg::client_none;
        if (prg.req && grant_q != mem_pkg::client_prg) begin
            grant_d = mem_pkg::client_prg;  // PRG wins ties.
        end else if (chr.req && grant_q != mem_pkg::client_chr) begin
            grant_d = mem_pkg::client_chr;
        end
    end

    always_comb begin
        if (grant_d == mem_pkg::client_prg) begin
            sel_we    = prg.we;
            sel_addr  = prg.addr;
            sel_wdata = prg.wdata;
        end else begin
            sel_we    = chr.we;
            sel_addr  = chr.addr;
            sel_wdata = chr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            grant_q <= mem_pkg::client_none;
        end else begin
            grant_q <= grant_d;
        end
    end

    // ************************************************************
    // Shared RAM
    // ************************************************************
    always_ff @(posedge clk) begin
        if (grant_d != mem_pkg::client_none) begin
            if (sel_we) begin
                ram[sel_addr] <= sel_wdata;
            end
            rdata_q <= ram[sel_addr];  // Read before write.
        end
    end

    assign prg.ack   = grant_q == mem_pkg::client_prg;
    assign chr.ack   = grant_q == mem_pkg::client_chr;
    assign prg.rdata = rdata_q;
    assign chr.rdata = rdata_q;

endmodule

`default_nettype wire

//--- logic/cart_core.sv
`timescale 1ns/10ps
`default_nettype none

module cart_core #(
    parameter int MEM_ADDR_BITS = 15  // 14 to 16 bits.
) (
    input  wire logic                clk,
    input  wire logic                async_nreset,
    // Console CPU bus.
    input  wire logic                m2,
    input  wire cart_pkg::cpu_addr_t cpu_addr,
    input  wire cart_pkg::bus_data_t cpu_data_in,
    input  wire logic                cpu_rw,
    input  wire logic                romsel,
    output cart_pkg::bus_data_t      cpu_data_out,
    output logic                     cpu_oe,
    // Console PPU bus.
    input  wire logic                ppu_rd,
    input  wire logic                ppu_wr,
    input  wire cart_pkg::ppu_addr_t ppu_addr,
    input  wire cart_pkg::bus_data_t ppu_data_in,
    output cart_pkg::bus_data_t      ppu_data_out,
    output logic                     ppu_oe,
    output logic                     ciram_a10,
    output logic                     ciram_ce
);

    cart_pkg::map_cfg_t map_cfg;

    mem_chan_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) ch_prg ();
    mem_chan_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) ch_chr ();

    prg_port #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_prg_port (
        .clk          (clk),
        .async_nreset (async_nreset),
        .m2           (m2),
        .cpu_addr     (cpu_addr),
        .cpu_data_in  (cpu_data_in),
        .cpu_rw       (cpu_rw),
        .romsel       (romsel),
        .cpu_data_out (cpu_data_out),
        .cpu_oe       (cpu_oe),
        .map_cfg      (map_cfg),
        .mem          (ch_prg.controller)
    );

    chr_port #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_chr_port (
        .clk          (clk),
        .async_nreset (async_nreset),
        .ppu_rd       (ppu_rd),
        .ppu_wr       (ppu_wr),
        .ppu_addr     (ppu_addr),
        .ppu_data_in  (ppu_data_in),
        .map_cfg      (map_cfg),
        .ppu_data_out (ppu_data_out),
        .ppu_oe       (ppu_oe),
        .ciram_a10    (ciram_a10),
        .ciram_ce     (ciram_ce),
        .mem          (ch_chr.controller)
    );

    mem_arbiter #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_mem_arbiter (
        .clk          (clk),
        .async_nreset (async_nreset),
        .prg          (ch_prg.memory),
        .chr          (ch_chr.memory)
    );

endmodule

`default_nettype wire

//--- dv/cart_properties.sv
`timescale 1ns/10ps
`default_nettype none

module cart_properties #(
    parameter int                   ADDR_BITS = 15,
    parameter mem_pkg::mem_client_e CLIENT    = mem_pkg::client_prg
) (
    input wire logic                 clk,
    input wire logic                 async_nreset,
    input wire logic                 req,
    input wire logic                 we,
    input wire logic [ADDR_BITS-1:0] addr,
    input wire mem_pkg::mem_data_t   wdata,
    input wire logic                 ack,
    input wire logic                 oe,
    input wire logic                 oe_gate  // M2 on the CPU side, ciram_ce on the PPU side.
);

    // CPU output enable lags M2, so only its rise is checked.
    localparam bit OE_ON_RISE = CLIENT == mem_pkg::client_prg;

    int fail_count = 0;

    // ************************************************************
    // Memory channel
    // ************************************************************
    ack_pulse: assert property (@(posedge clk) disable iff (!async_nreset) ack |=> !ack) else begin
        $error("Client %0d saw ack for more than one cycle.", CLIENT);
        fail_count++;
    end

    req_stable: assert property (@(posedge clk) disable iff (!async_nreset)
        req && !ack |=> req && $stable({we, addr, wdata})) else begin
        $error("Client %0d changed its request before ack.", CLIENT);
        fail_count++;
    end

    // ************************************************************
    // Output enables
    // ************************************************************
    oe_rise: assert property (@(posedge clk) disable iff (!async_nreset)
        OE_ON_RISE && $rose(oe) |-> oe_gate) else begin
        $error("cpu_oe rose while M2 was low.");
        fail_count++;
    end

    oe_level: assert property (@(posedge clk) disable iff (!async_nreset)
        !OE_ON_RISE && oe |-> oe_gate) else begin
        $error("ppu_oe was high while ciram_ce was low.");
        fail_count++;
    end

endmodule

bind prg_port cart_properties #(
    .ADDR_BITS (MEM_ADDR_BITS),
    .CLIENT    (mem_pkg::client_prg)
) prg_props (
    .clk          (clk),
    .async_nreset (async_nreset),
    .req          (mem.req),
    .we           (mem.we),
    .addr         (mem.addr),
    .wdata        (mem.wdata),
    .ack          (mem.ack),
    .oe           (cpu_oe),
    .oe_gate      (m2)
);

bind chr_port cart_properties #(
    .ADDR_BITS (MEM_ADDR_BITS),
    .CLIENT    (mem_pkg::client_chr)
) chr_props (
    .clk          (clk),
    .async_nreset (async_nreset),
    .req          (mem.req),
    .we           (mem.we),
    .addr         (mem.addr),
    .wdata        (mem.wdata),
    .ack          (mem.ack),
    .oe           (ppu_oe),
    .oe_gate      (ciram_ce)
);

`default_nettype wire

//--- dv/cart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cart_tb;

    localparam int MEM_ADDR_BITS = 15;
    localparam int OP_CYCLES = 16;  // Setup, strobe and release of one bus task.
    localparam int NUM_OPS = 96;
    localparam int TIMEOUT_CYCLES = NUM_OPS * OP_CYCLES + 200;

    logic                clk = 1'b0;
    logic                async_nreset;
    logic                m2;
    cart_pkg::cpu_addr_t cpu_addr;
    cart_pkg::bus_data_t cpu_data_in;
    logic                cpu_rw;
    logic                romsel;
    cart_pkg::bus_data_t cpu_data_out;
    logic                cpu_oe;
    logic                ppu_rd;
    logic                ppu_wr;
    cart_pkg::ppu_addr_t ppu_addr;
    cart_pkg::bus_data_t ppu_data_in;
    cart_pkg::bus_data_t ppu_data_out;
    logic                ppu_oe;
    logic                ciram_a10;
    logic                ciram_ce;

    logic [31:0]         lfsr = 32'he317_1189;
    cart_pkg::map_cfg_t  cfg;  // Shadow of the mapper register.
    logic [7:0]          shadow [2**MEM_ADDR_BITS];
    logic [12:0]         offs [8];
    string               name_q [$];
    logic [7:0]          exp_q [$];
    logic [7:0]          act_q [$];
    int                  check_count = 0;
    int                  error_count = 0;
    int                  cycle_count = 0;

    cart_core #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) dut (
        .clk          (clk),
        .async_nreset (async_nreset),
        .m2           (m2),
        .cpu_addr     (cpu_addr),
        .cpu_data_in  (cpu_data_in),
        .cpu_rw       (cpu_rw),
        .romsel       (romsel),
        .cpu_data_out (cpu_data_out),
        .cpu_oe       (cpu_oe),
        .ppu_rd       (ppu_rd),
        .ppu_wr       (ppu_wr),
        .ppu_addr     (ppu_addr),
        .ppu_data_in  (ppu_data_in),
        .ppu_data_out (ppu_data_out),
        .ppu_oe       (ppu_oe),
        .ciram_a10    (ciram_a10),
        .ciram_ce     (ciram_ce)
    );

    always #20 clk = ~clk;

    // ************************************************************
    // Reference model
    // ************************************************************
    // Taps x^32 + x^22 + x^2 + x + 1.
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [MEM_ADDR_BITS-1:0] ref_addr(input logic [2:0] bank,
                                                          input logic [12:0] off);
        logic [15:0] full;
        full = {bank, off};
        return full[MEM_ADDR_BITS-1:0];  // Bank bits above the memory size fall away.
    endfunction

    task automatic queue_check(input string name, input logic [7:0] exp, input logic [7:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // ************************************************************
    // Bus tasks
    // ************************************************************
    task automatic cpu_bus(input cart_pkg::cpu_addr_t addr, input cart_pkg::bus_data_t data,
                           input logic rw, input logic rsel,
                           output cart_pkg::bus_data_t rdata, output logic oe);
        @(negedge clk);
        cpu_addr = addr;
        cpu_data_in = data;
        cpu_rw = rw;
        romsel = rsel;
        @(negedge clk);
        m2 = 1'b1;
        repeat (10) @(negedge clk);
        rdata = cpu_data_out;
        oe = cpu_oe;
        m2 = 1'b0;
        repeat (4) @(negedge clk);  // Bus stays put past the synced M2 fall.
        cpu_rw = 1'b1;
        romsel = 1'b1;
    endtask

    task automatic ppu_bus(input cart_pkg::ppu_addr_t addr, input cart_pkg::bus_data_t data,
                           input logic wr, output cart_pkg::bus_data_t rdata, output logic oe);
        @(negedge clk);
        ppu_addr = addr;
        ppu_data_in = data;
        @(negedge clk);
        ppu_wr = !wr;
        ppu_rd = wr;
        repeat (10) @(negedge clk);
        rdata = ppu_data_out;
        oe = ppu_oe;
        ppu_wr = 1'b1;
        ppu_rd = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic set_cfg(input logic [2:0] prg, input logic [2:0] chr, input logic mir);
        cart_pkg::bus_data_t rdata;
        logic oe;
        cfg = {mir, chr, prg};
        cpu_bus(15'h0000, {1'b0, mir, chr, prg}, 1'b0, 1'b0, rdata, oe);
    endtask

    task automatic cpu_write(input logic [12:0] off, input logic [7:0] data);
        cart_pkg::bus_data_t rdata;
        logic oe;
        cpu_bus({2'b11, off}, data, 1'b0, 1'b1, rdata, oe);
        shadow[ref_addr(cfg[2:0], off)] = data;
    endtask

    task automatic cpu_read(input string name, input logic [12:0] off);
        logic [7:0] exp;
        cart_pkg::bus_data_t act;
        logic oe;
        exp = shadow[ref_addr(cfg[2:0], off)];
        cpu_bus({2'b11, off}, 8'h00, 1'b1, 1'b1, act, oe);
        queue_check(name, exp, act);
        queue_check({name, "_oe"}, 8'h01, {7'b0, oe});
    endtask

    task automatic ppu_write(input logic [12:0] off, input logic [7:0] data);
        cart_pkg::bus_data_t rdata;
        logic oe;
        ppu_bus({1'b0, off}, data, 1'b1, rdata, oe);
        shadow[ref_addr(cfg[5:3], off)] = data;
    endtask

    task automatic ppu_read(input string name, input logic [12:0] off);
        logic [7:0] exp;
        cart_pkg::bus_data_t act;
        logic oe;
        exp = shadow[ref_addr(cfg[5:3], off)];
        ppu_bus({1'b0, off}, 8'h00, 1'b0, act, oe);
        queue_check(name, exp, act);
        queue_check({name, "_oe"}, 8'h01, {7'b0, oe});
    endtask

    task automatic check_nametable(input cart_pkg::ppu_addr_t addr);
        cart_pkg::bus_data_t rdata;
        logic oe;
        ppu_bus(addr, 8'h00, 1'b0, rdata, oe);
        queue_check("nametable_oe", 8'h00, {7'b0, oe});
        queue_check("nametable_ce", 8'h00, {7'b0, ciram_ce});
        queue_check("nametable_a10", {7'b0, cfg[6] ? addr[11] : addr[10]}, {7'b0, ciram_a10});
    endtask

    task automatic report_and_finish(input logic timed_out);
        int prop_fails;
        prop_fails = dut.u_prg_port.prg_props.fail_count + dut.u_chr_port.chr_props.fail_count;
        $display("Checks: %0d, value errors: %0d, property failures: %0d",
                 check_count, error_count, prop_fails);
        if (error_count == 0 && prop_fails == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // ************************************************************
    // Compare and timeout
    // ************************************************************
    always @(posedge clk) begin
        while (name_q.size() > 0) begin
            check_count++;
            assert (act_q[0] === exp_q[0]) else begin
                error_count++;
                $display("** Error %s: expected %h, actual %h", name_q[0], exp_q[0], act_q[0]);
            end
            void'(name_q.pop_front());
            void'(exp_q.pop_front());
            void'(act_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
        report_and_finish(1'b1);
    end

    // ************************************************************
    // Test sequence
    // ************************************************************
    initial begin
        async_nreset = 1'b0;
        m2 = 1'b0;
        cpu_addr = '0;
        cpu_data_in = '0;
        cpu_rw = 1'b1;
        romsel = 1'b1;
        ppu_rd = 1'b1;
        ppu_wr = 1'b1;
        ppu_addr = '0;
        ppu_data_in = '0;
        cfg = '0;
        repeat (2) @(negedge clk);
        async_nreset = 1'b1;

        queue_check("reset_cpu_oe", 8'h00, {7'b0, cpu_oe});
        queue_check("reset_ppu_oe", 8'h00, {7'b0, ppu_oe});
        cpu_write(13'h0123, 8'h5a);
        cpu_read("reset_bank0", 13'h0123);

        for (int i = 0; i < 8; i++) begin
            set_cfg(3'(i), 3'd0, 1'b0);
            offs[i] = 13'(rand_bits(13));
            cpu_write(offs[i], 8'(rand_bits(8)));
        end
        for (int i = 7; i >= 0; i--) begin
            set_cfg(3'(i), 3'd0, 1'b0);
            cpu_read("prg_banks", offs[i]);
        end

        for (int i = 0; i < 8; i++) begin
            set_cfg(3'd0, 3'(i), 1'b0);
            offs[i] = 13'(rand_bits(13));
            ppu_write(offs[i], 8'(rand_bits(8)));
        end
        for (int i = 7; i >= 0; i--) begin
            set_cfg(3'd0, 3'(i), 1'b0);
            ppu_read("chr_banks", offs[i]);
        end

        for (int i = 0; i < 4; i++) begin
            set_cfg(3'(i), 3'(i), 1'b0);
            offs[i] = 13'(rand_bits(13));
            cpu_write(offs[i], 8'(rand_bits(8)));
            ppu_read("cross_visibility", offs[i]);
        end

        // Bits 11:10 sweep all four values under each mirroring.
        for (int m = 0; m < 2; m++) begin
            set_cfg(3'd1, 3'd2, 1'(m));
            for (int k = 0; k < 4; k++) begin
                check_nametable({1'b1, 1'(rand_bits(1)), 2'(k), 10'(rand_bits(10))});
            end
        end

        // Both reads reach the arbiter in the same cycle.
        for (int i = 0; i < 4; i++) begin
            set_cfg(3'(i), 3'(7 - i), 1'b0);
            fork
                cpu_read("contention_cpu", offs[i]);
                ppu_read("contention_ppu", offs[3 - i]);
            join
        end

        repeat (2) @(posedge clk);
        report_and_finish(1'b0);
    end

endmodule

`default_nettype wire

//--- src.f
logic/cart_pkg.sv
logic/mem_pkg.sv
logic/mem_chan_if.sv
logic/prg_port.sv
logic/chr_port.sv
logic/mem_arbiter.sv
logic/cart_core.sv
dv/cart_properties.sv
dv/cart_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the cart_core testbench with Verilator.
# Exits 0 only when the simulation output holds the pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cart_tb -Mdir obj_dir -f src.f; then
    echo "Verilator compile failed."
    exit 1
fi

output=$(./obj_dir/Vcart_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1
